//--- design/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// request and bus address width
`define CACHE_ADDR_WIDTH 32

// one doubleword per request and per bus beat
`define CACHE_WORD_WIDTH 64

// line size in bytes, two beats per line
`define CACHE_LINE_BYTES 16

// number of sets
`define CACHE_SETS 16

// associativity
`define CACHE_WAYS 4

// victim LFSR reset value, must be nonzero
`define CACHE_LFSR_SEED 16'h0001

`endif

//--- design/cachePkg.sv
`default_nettype none

`include "cache_config.svh"

package cachePkg;
    // geometry derived from the config macros
    localparam int offsetBits = $clog2(`CACHE_LINE_BYTES);
    localparam int setBits = $clog2(`CACHE_SETS);
    localparam int wayBits = $clog2(`CACHE_WAYS);
    localparam int tagBits = `CACHE_ADDR_WIDTH - setBits - offsetBits;
    localparam int setCount = `CACHE_SETS;
    localparam int wayCount = `CACHE_WAYS;
    localparam int lineCount = `CACHE_SETS * `CACHE_WAYS;
    localparam logic [15:0] lfsrSeed = `CACHE_LFSR_SEED;

    typedef logic [`CACHE_ADDR_WIDTH-1:0] addrT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [setBits-1:0] setT;
    typedef logic [wayBits-1:0] wayT;
    typedef logic [`CACHE_WORD_WIDTH-1:0] wordT;
    typedef logic [`CACHE_WORD_WIDTH/8-1:0] maskT;
    // lower doubleword at bits 63:0
    typedef logic [`CACHE_LINE_BYTES*8-1:0] lineT;
    // {set, way}
    typedef logic [setBits+wayBits-1:0] lineIndexT;

    typedef enum logic [2:0] {
        stateIdle,
        stateLookup,
        stateMiss,
        stateWriteback,
        stateRefill
    } cacheStateT;
endpackage

`default_nettype wire

//--- design/entryArray.sv
`default_nettype none

module entryArray #(
    parameter type entryT = logic,
    parameter int depth = 16
) (
    input  wire logic                     clock,
    input  wire logic                     writeEnable,
    input  wire logic [$clog2(depth)-1:0] writeIndex,
    input  wire entryT                    writeData,
    input  wire logic [$clog2(depth)-1:0] readIndex,
    output entryT                         readData
);
    // plain register file, no reset on contents
    entryT entries [depth];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            entries[writeIndex] <= writeData;
        end
    end

    // read is combinational, new data visible after the edge
    assign readData = entries[readIndex];
endmodule

`default_nettype wire

//--- design/tagDirectory.sv
`default_nettype none

module tagDirectory (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire cachePkg::setT  lookupSet,
    input  wire cachePkg::tagT  lookupTag,
    input  wire cachePkg::wayT  victimWay,
    input  wire cachePkg::wayT  updateWay,
    input  wire logic           tagWrite,
    input  wire logic           validSet,
    input  wire logic           dirtySet,
    input  wire logic           dirtyClear,
    output logic                hit,
    output cachePkg::wayT       hitWay,
    output logic                victimDirty,
    output cachePkg::tagT       victimTag
);
    import cachePkg::*;

    tagT wayTags [wayCount];
    logic [wayCount-1:0] hitVec;
    // one bit per line, indexed by {set, way}
    logic [lineCount-1:0] validBits;
    logic [lineCount-1:0] dirtyBits;
    lineIndexT updateIndex;
    lineIndexT victimIndex;

    assign updateIndex = {lookupSet, updateWay};
    assign victimIndex = {lookupSet, victimWay};

    for (genvar way = 0; way < wayCount; way++) begin : wayGen
        // tag store for one way, written only during refill
        entryArray #(
            .entryT(tagT),
            .depth (setCount)
        ) tagArray_i (
            .clock      (clock),
            .writeEnable(tagWrite && (updateWay == wayT'(way))),
            .writeIndex (lookupSet),
            .writeData  (lookupTag),
            .readIndex  (lookupSet),
            .readData   (wayTags[way])
        );

        // compare all ways of the set at once
        assign hitVec[way] = validBits[lineIndexT'({lookupSet, wayT'(way)})]
                             && (wayTags[way] == lookupTag);
    end

    assign hit = |hitVec;

    // priority to the highest way
    always_comb begin
        hitWay = '0;
        for (int way = 0; way < wayCount; way++) begin
            if (hitVec[way]) begin
                hitWay = wayT'(way);
            end
        end
    end

    // status of the chosen victim
    assign victimTag = wayTags[victimWay];
    assign victimDirty = validBits[victimIndex] && dirtyBits[victimIndex];

    always_ff @(posedge clock) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (validSet) begin
                validBits[updateIndex] <= 1'b1;
            end
            // write hit marks dirty, finished writeback cleans
            if (dirtySet) begin
                dirtyBits[updateIndex] <= 1'b1;
            end else if (dirtyClear) begin
                dirtyBits[updateIndex] <= 1'b0;
            end
        end
    end
endmodule

`default_nettype wire

//--- design/lineStore.sv
`default_nettype none

module lineStore (
    input  wire logic                clock,
    input  wire cachePkg::lineIndexT lineIndex,
    input  wire logic                wordSel,
    input  wire logic                storeWrite,
    input  wire cachePkg::wordT      storeWdata,
    input  wire cachePkg::maskT      storeMask,
    input  wire logic                refillBeat,
    input  wire cachePkg::wordT      refillData,
    output cachePkg::wordT           readWord,
    output cachePkg::lineT           readLine
);
    import cachePkg::*;

    localparam int wordBits = $bits(wordT);

    lineT storedLine;
    lineT nextLine;
    wordT mergedWord;
    wordT newWord;

    // all 64 lines in one array
    entryArray #(
        .entryT(lineT),
        .depth (lineCount)
    ) dataArray_i (
        .clock      (clock),
        .writeEnable(storeWrite || refillBeat),
        .writeIndex (lineIndex),
        .writeData  (nextLine),
        .readIndex  (lineIndex),
        .readData   (storedLine)
    );

    assign readLine = storedLine;
    // bit 3 of the address picks the half
    assign readWord = wordSel ? storedLine[wordBits +: wordBits] : storedLine[0 +: wordBits];

    // byte merge for write hits
    always_comb begin
        mergedWord = readWord;
        for (int b = 0; b < $bits(maskT); b++) begin
            if (storeMask[b]) begin
                mergedWord[b*8 +: 8] = storeWdata[b*8 +: 8];
            end
        end
    end

    // refill beat replaces the whole half
    assign newWord = refillBeat ? refillData : mergedWord;

    always_comb begin
        nextLine = storedLine;
        if (wordSel) begin
            nextLine[wordBits +: wordBits] = newWord;
        end else begin
            nextLine[0 +: wordBits] = newWord;
        end
    end
endmodule

`default_nettype wire

//--- design/missController.sv
`default_nettype none

module missController (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                reqValid,
    input  wire logic                reqWrite,
    input  wire cachePkg::addrT      reqAddr,
    input  wire cachePkg::wordT      reqWdata,
    input  wire cachePkg::maskT      reqMask,
    output cachePkg::wordT           respData,
    output logic                     respDone,
    output cachePkg::setT            lookupSet,
    output cachePkg::tagT            lookupTag,
    output cachePkg::wayT            victimWay,
    output cachePkg::wayT            updateWay,
    output logic                     tagWrite,
    output logic                     validSet,
    output logic                     dirtySet,
    output logic                     dirtyClear,
    input  wire logic                hit,
    input  wire cachePkg::wayT       hitWay,
    input  wire logic                victimDirty,
    input  wire cachePkg::tagT       victimTag,
    output cachePkg::lineIndexT      lineIndex,
    output logic                     wordSel,
    output logic                     storeWrite,
    output cachePkg::wordT           storeWdata,
    output cachePkg::maskT           storeMask,
    output logic                     refillBeat,
    output cachePkg::wordT           refillData,
    input  wire cachePkg::wordT      readWord,
    input  wire cachePkg::lineT      readLine,
    output logic                     fetchStart,
    output cachePkg::addrT           fetchAddr,
    output logic                     evictStart,
    output cachePkg::addrT           evictAddr,
    output cachePkg::lineT           evictLine,
    input  wire logic                beatValid,
    input  wire logic                beatSecond,
    input  wire cachePkg::wordT      beatData,
    input  wire logic                fetchDone,
    input  wire logic                evictDone
);
    import cachePkg::*;

    cacheStateT state;
    cacheStateT nextState;
    logic [15:0] lfsr;
    wayT chosenWay;
    // request captured in idle, held until done
    logic reqWriteHeld;
    addrT reqAddrHeld;
    wordT reqWdataHeld;
    maskT reqMaskHeld;
    logic inLookup;
    logic inMiss;
    logic inRefill;

    assign inLookup = (state == stateLookup);
    assign inMiss = (state == stateMiss);
    assign inRefill = (state == stateRefill);

    always_comb begin
        nextState = state;
        unique case (state)
            stateIdle:      if (reqValid) nextState = stateLookup;
            stateLookup:    nextState = hit ? stateIdle : stateMiss;
            // dirty victim goes out before the fetch
            stateMiss:      nextState = victimDirty ? stateWriteback : stateRefill;
            stateWriteback: if (evictDone) nextState = stateMiss;
            stateRefill:    if (fetchDone) nextState = stateLookup;
            default:        nextState = stateIdle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stateIdle;
            lfsr <= lfsrSeed;
        end else begin
            state <= nextState;
            // free running, taps 0 2 3 5
            lfsr <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        end
    end

    always_ff @(posedge clock) begin
        if (state == stateIdle && reqValid) begin
            reqWriteHeld <= reqWrite;
            reqAddrHeld <= reqAddr;
            reqWdataHeld <= reqWdata;
            reqMaskHeld <= reqMask;
        end
        // victim picked as lookup misses
        if (inLookup && !hit) begin
            chosenWay <= lfsr[wayBits-1:0];
        end
    end

    // directory side
    assign lookupSet = reqAddrHeld[offsetBits +: setBits];
    assign lookupTag = reqAddrHeld[$bits(addrT)-1 -: tagBits];
    assign victimWay = chosenWay;
    assign updateWay = inLookup ? hitWay : chosenWay;
    assign tagWrite = inRefill && beatValid && !beatSecond;
    assign validSet = inRefill && beatValid && beatSecond;
    assign dirtySet = storeWrite;
    assign dirtyClear = (state == stateWriteback) && evictDone;

    // data side
    assign lineIndex = {lookupSet, updateWay};
    assign wordSel = inRefill ? beatSecond : reqAddrHeld[offsetBits-1];
    assign storeWrite = inLookup && hit && reqWriteHeld;
    assign storeWdata = reqWdataHeld;
    assign storeMask = reqMaskHeld;
    assign refillBeat = inRefill && beatValid;
    assign refillData = beatData;

    // requester side, answered in the lookup cycle
    assign respData = readWord;
    assign respDone = inLookup && hit;

    // burst commands with line-aligned addresses
    assign fetchStart = inMiss && !victimDirty;
    assign fetchAddr = {lookupTag, lookupSet, {offsetBits{1'b0}}};
    assign evictStart = inMiss && victimDirty;
    assign evictAddr = {victimTag, lookupSet, {offsetBits{1'b0}}};
    assign evictLine = readLine;
endmodule

`default_nettype wire

//--- design/burstPort.sv
`default_nettype none

module burstPort (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           fetchStart,
    input  wire cachePkg::addrT fetchAddr,
    input  wire logic           evictStart,
    input  wire cachePkg::addrT evictAddr,
    input  wire cachePkg::lineT evictLine,
    output logic                beatValid,
    output logic                beatSecond,
    output cachePkg::wordT      beatData,
    output logic                fetchDone,
    output logic                evictDone,
    output logic                arValid,
    output cachePkg::addrT      arAddr,
    input  wire logic           arReady,
    input  wire logic           rValid,
    input  wire logic           rLast,
    input  wire cachePkg::wordT rData,
    output logic                rReady,
    output logic                awValid,
    output cachePkg::addrT      awAddr,
    input  wire logic           awReady,
    output logic                wValid,
    output logic                wLast,
    output cachePkg::wordT      wData,
    input  wire logic           wReady
);
    import cachePkg::*;

    localparam int wordBits = $bits(wordT);

    // beat index, shared since one burst at a time
    logic beatCount;
    lineT lineHeld;
    logic readBeat;
    logic writeBeat;

    assign readBeat = rValid && rReady;
    assign writeBeat = wValid && wReady;

    always_ff @(posedge clock) begin
        if (reset) begin
            arValid <= 1'b0;
            rReady <= 1'b0;
            awValid <= 1'b0;
            wValid <= 1'b0;
            beatCount <= 1'b0;
        end else begin
            // read burst: address phase then data phase
            if (fetchStart) begin
                arValid <= 1'b1;
            end else if (arValid && arReady) begin
                arValid <= 1'b0;
                rReady <= 1'b1;
            end
            if (readBeat && rLast) begin
                rReady <= 1'b0;
            end
            // write burst, two data beats after the address
            if (evictStart) begin
                awValid <= 1'b1;
            end else if (awValid && awReady) begin
                awValid <= 1'b0;
                wValid <= 1'b1;
            end
            if (writeBeat && beatCount) begin
                wValid <= 1'b0;
            end
            if (readBeat) begin
                beatCount <= !rLast;
            end else if (writeBeat) begin
                beatCount <= !beatCount;
            end
        end
    end

    // addresses and victim line kept for the whole burst
    always_ff @(posedge clock) begin
        if (fetchStart) begin
            arAddr <= fetchAddr;
        end
        if (evictStart) begin
            awAddr <= evictAddr;
            lineHeld <= evictLine;
        end
    end

    // beat 0 is the lower doubleword
    assign wData = beatCount ? lineHeld[wordBits +: wordBits] : lineHeld[0 +: wordBits];
    assign wLast = wValid && beatCount;

    assign beatValid = readBeat;
    assign beatSecond = beatCount;
    assign beatData = rData;
    assign fetchDone = readBeat && rLast;
    assign evictDone = writeBeat && beatCount;
endmodule

`default_nettype wire

//--- design/cacheTop.sv
`default_nettype none

module cacheTop (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           reqValid,
    input  wire logic           reqWrite,
    input  wire cachePkg::addrT reqAddr,
    input  wire cachePkg::wordT reqWdata,
    input  wire cachePkg::maskT reqMask,
    output cachePkg::wordT      respData,
    output logic                respDone,
    output logic                arValid,
    output cachePkg::addrT      arAddr,
    input  wire logic           arReady,
    input  wire logic           rValid,
    input  wire logic           rLast,
    input  wire cachePkg::wordT rData,
    output logic                rReady,
    output logic                awValid,
    output cachePkg::addrT      awAddr,
    input  wire logic           awReady,
    output logic                wValid,
    output logic                wLast,
    output cachePkg::wordT      wData,
    input  wire logic           wReady
);
    import cachePkg::*;

    // controller to directory
    wire setT lookupSet;
    wire tagT lookupTag;
    wire wayT victimWay;
    wire wayT updateWay;
    wire logic tagWrite;
    wire logic validSet;
    wire logic dirtySet;
    wire logic dirtyClear;
    // directory status
    wire logic hit;
    wire wayT hitWay;
    wire logic victimDirty;
    wire tagT victimTag;
    // line store controls and read data
    wire lineIndexT lineIndex;
    wire logic wordSel;
    wire logic storeWrite;
    wire wordT storeWdata;
    wire maskT storeMask;
    wire logic refillBeat;
    wire wordT refillData;
    wire wordT readWord;
    wire lineT readLine;
    // burst commands and beat results
    wire logic fetchStart;
    wire addrT fetchAddr;
    wire logic evictStart;
    wire addrT evictAddr;
    wire lineT evictLine;
    wire logic beatValid;
    wire logic beatSecond;
    wire wordT beatData;
    wire logic fetchDone;
    wire logic evictDone;

    // port names match the nets above
    tagDirectory tagDir_i (.*);

    lineStore lineStore_i (.*);

    missController missCtrl_i (.*);

    burstPort burstPort_i (.*);
endmodule

`default_nettype wire

//--- verif/cache_assertions.sv
`default_nettype none

module cacheAssertions (
    input wire logic           clock,
    input wire logic           reset,
    input wire logic           arValid,
    input wire logic           arReady,
    input wire cachePkg::addrT arAddr,
    input wire logic           awValid,
    input wire logic           awReady,
    input wire cachePkg::addrT awAddr,
    input wire logic           wValid,
    input wire logic           wReady,
    input wire logic           wLast,
    input wire cachePkg::wordT wData
);
    // which write beat is on the bus
    logic secondBeat;
    // failed assertions so far
    int failCount = 0;

    always_ff @(posedge clock) begin
        if (reset) begin
            secondBeat <= 1'b0;
        end else if (wValid && wReady) begin
            secondBeat <= !secondBeat;
        end
    end

    // valid and payload held until the transfer
    arHold: assert property (@(posedge clock) disable iff (reset)
        arValid && !arReady |=> arValid && $stable(arAddr))
        else begin
            failCount++;
            $error("arValid or arAddr changed before the transfer");
        end

    awHold: assert property (@(posedge clock) disable iff (reset)
        awValid && !awReady |=> awValid && $stable(awAddr))
        else begin
            failCount++;
            $error("awValid or awAddr changed before the transfer");
        end

    wHold: assert property (@(posedge clock) disable iff (reset)
        wValid && !wReady |=> wValid && $stable(wData))
        else begin
            failCount++;
            $error("wValid or wData changed before the transfer");
        end

    // wLast only with the second beat
    lastBeat: assert property (@(posedge clock) disable iff (reset)
        wLast == (wValid && secondBeat))
        else begin
            failCount++;
            $error("wLast does not match the write beat");
        end

    oneBurst: assert property (@(posedge clock) disable iff (reset)
        !(arValid && awValid))
        else begin
            failCount++;
            $error("read and write address valid at the same time");
        end
endmodule

`default_nettype wire

//--- verif/memoryModel.sv
`default_nettype none

`include "cache_config.svh"

module memoryModel (
    input  wire logic                         clock,
    input  wire logic                         arValid,
    input  wire logic [`CACHE_ADDR_WIDTH-1:0] arAddr,
    output logic                              arReady,
    output logic                              rValid,
    output logic                              rLast,
    output logic [`CACHE_WORD_WIDTH-1:0]      rData,
    input  wire logic                         rReady,
    input  wire logic                         awValid,
    input  wire logic [`CACHE_ADDR_WIDTH-1:0] awAddr,
    output logic                              awReady,
    input  wire logic                         wValid,
    input  wire logic [`CACHE_WORD_WIDTH-1:0] wData,
    output logic                              wReady,
    output int                                stallCount
);
    typedef logic [`CACHE_ADDR_WIDTH-1:0] busAddrT;
    typedef logic [`CACHE_WORD_WIDTH-1:0] busWordT;

    localparam int beatBytes = `CACHE_WORD_WIDTH / 8;
    localparam int stallLimit = 100;

    // sparse contents, doubleword keyed
    busWordT memory [busAddrT];
    int readStalls = 0;
    int writeStalls = 0;

    assign stallCount = readStalls + writeStalls;

    // whole address goes into the fill value
    function automatic busWordT patternWord(busAddrT addr);
        return {addr ^ 32'h5a5a_c3c3, ~addr};
    endfunction

    function automatic busWordT readMemory(busAddrT addr);
        if (memory.exists(addr)) begin
            return memory[addr];
        end
        return patternWord(addr);
    endfunction

    // LCG step, bit 16 picks the extra delay cycle
    function automatic logic [31:0] nextLcg(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin : readSide
        logic [31:0] lcg;
        logic pending;
        int waitCount;
        busAddrT lineAddr;

        lcg = 32'hd5fb;
        arReady = 1'b0;
        rValid = 1'b0;
        rLast = 1'b0;
        rData = '0;
        forever begin
            @(negedge clock);
            pending = arValid;
            if (arValid && arReady) begin
                lineAddr = arAddr;
                @(posedge clock);
                #2;
                arReady = 1'b0;
                for (int beat = 0; beat < 2; beat++) begin
                    lcg = nextLcg(lcg);
                    if (lcg[16]) begin
                        @(posedge clock);
                        #2;
                    end
                    rValid = 1'b1;
                    rLast = (beat == 1);
                    rData = readMemory(lineAddr + busAddrT'(beat * beatBytes));
                    waitCount = 0;
                    @(negedge clock);
                    while (!rReady && waitCount < stallLimit) begin
                        @(negedge clock);
                        waitCount++;
                    end
                    if (!rReady) begin
                        $display("memory model: rReady stayed low for %0d cycles", stallLimit);
                        readStalls++;
                    end
                    @(posedge clock);
                    #2;
                    rValid = 1'b0;
                    rLast = 1'b0;
                end
            end else begin
                // a waiting arValid gets ready next cycle
                @(posedge clock);
                #2;
                lcg = nextLcg(lcg);
                arReady = pending || lcg[16];
            end
        end
    end

    initial begin : writeSide
        logic [31:0] lcg;
        logic pending;
        int waitCount;
        busAddrT lineAddr;

        lcg = 32'hd5fb;
        awReady = 1'b0;
        wReady = 1'b0;
        forever begin
            @(negedge clock);
            pending = awValid;
            if (awValid && awReady) begin
                lineAddr = awAddr;
                @(posedge clock);
                #2;
                awReady = 1'b0;
                for (int beat = 0; beat < 2; beat++) begin
                    lcg = nextLcg(lcg);
                    if (lcg[16]) begin
                        @(posedge clock);
                        #2;
                    end
                    wReady = 1'b1;
                    waitCount = 0;
                    @(negedge clock);
                    while (!wValid && waitCount < stallLimit) begin
                        @(negedge clock);
                        waitCount++;
                    end
                    // beat taken at the coming edge
                    if (wValid) begin
                        memory[lineAddr + busAddrT'(beat * beatBytes)] = wData;
                    end else begin
                        $display("memory model: wValid stayed low for %0d cycles", stallLimit);
                        writeStalls++;
                    end
                    @(posedge clock);
                    #2;
                    wReady = 1'b0;
                end
            end else begin
                @(posedge clock);
                #2;
                lcg = nextLcg(lcg);
                awReady = pending || lcg[16];
            end
        end
    end
endmodule

`default_nettype wire

//--- verif/cacheTb.sv
`default_nettype none

module cacheTb;
    import cachePkg::*;

    typedef struct packed {
        logic write;
        addrT addr;
        wordT data;
        maskT mask;
        logic [1:0] arExpect;
        logic evictExpect;
    } stepT;

    // expected read bursts per row
    localparam logic [1:0] arNone = 2'd0;
    localparam logic [1:0] arOne = 2'd1;
    localparam logic [1:0] arAny = 2'd2;
    localparam int stepCount = 13;
    localparam int doneTimeout = 200;

    // lines 1030 to 5030 all land in set 3, five lines for four ways
    localparam stepT steps [stepCount] = '{
        '{1'b0, 32'h0000_1030, 64'h0, 8'h00, arOne, 1'b0},
        '{1'b0, 32'h0000_1038, 64'h0, 8'h00, arNone, 1'b0},
        '{1'b1, 32'h0000_1038, 64'h1122_3344_5566_7788, 8'h0f, arNone, 1'b0},
        '{1'b0, 32'h0000_1038, 64'h0, 8'h00, arNone, 1'b0},
        '{1'b1, 32'h0000_2030, 64'ha1a2_a3a4_a5a6_a7a8, 8'hff, arOne, 1'b0},
        '{1'b1, 32'h0000_3038, 64'hb1b2_b3b4_b5b6_b7b8, 8'hf0, arOne, 1'b0},
        '{1'b1, 32'h0000_4030, 64'hc1c2_c3c4_c5c6_c7c8, 8'h3c, arOne, 1'b0},
        '{1'b1, 32'h0000_5038, 64'hd1d2_d3d4_d5d6_d7d8, 8'h81, arOne, 1'b1},
        '{1'b0, 32'h0000_1038, 64'h0, 8'h00, arAny, 1'b0},
        '{1'b0, 32'h0000_2030, 64'h0, 8'h00, arAny, 1'b0},
        '{1'b0, 32'h0000_3038, 64'h0, 8'h00, arAny, 1'b0},
        '{1'b0, 32'h0000_4030, 64'h0, 8'h00, arAny, 1'b0},
        '{1'b0, 32'h0000_5038, 64'h0, 8'h00, arAny, 1'b0}
    };

    logic clock;
    logic reset;
    logic reqValid;
    logic reqWrite;
    addrT reqAddr;
    wordT reqWdata;
    maskT reqMask;
    wordT respData;
    logic respDone;
    logic arValid;
    addrT arAddr;
    logic arReady;
    logic rValid;
    logic rLast;
    wordT rData;
    logic rReady;
    logic awValid;
    addrT awAddr;
    logic awReady;
    logic wValid;
    logic wLast;
    wordT wData;
    logic wReady;
    int stallCount;

    int errorCount = 0;
    int arCount = 0;
    int awCount = 0;
    int badEvictCount = 0;
    addrT lastArAddr = '0;
    // expected memory contents, doubleword keyed
    wordT shadow [addrT];
    addrT writtenLines [$];

    cacheTop dut_i (.*);

    memoryModel memory_i (.*);

    bind burstPort cacheAssertions assertions_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // unwritten memory content, same rule as the memory model
    function automatic wordT patternWord(addrT addr);
        return {addr ^ 32'h5a5a_c3c3, ~addr};
    endfunction

    function automatic wordT mergeBytes(wordT oldWord, wordT newWord, maskT mask);
        wordT merged;
        merged = oldWord;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                merged[b*8 +: 8] = newWord[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic wordT expectedWord(addrT addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return patternWord(addr);
    endfunction

    function automatic logic isWrittenLine(addrT lineAddr);
        foreach (writtenLines[i]) begin
            if (writtenLines[i] == lineAddr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic compareValue(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    // respDone sampled mid-cycle, bounded by doneTimeout
    task automatic waitDone(output logic done, output int cycles, output wordT data);
        done = 1'b0;
        cycles = 0;
        data = '0;
        while (!done && cycles < doneTimeout) begin
            @(negedge clock);
            cycles++;
            if (respDone) begin
                done = 1'b1;
                data = respData;
            end
        end
    endtask

    // handshakes seen before the edge that completes them
    always @(negedge clock) begin
        if (!reset && arValid && arReady) begin
            arCount++;
            lastArAddr = arAddr;
        end
        if (!reset && awValid && awReady) begin
            awCount++;
            if (!isWrittenLine(awAddr)) begin
                $display("eviction of line %h that the test never wrote", awAddr);
                badEvictCount++;
            end
        end
    end

    initial begin : mainFlow
        stepT step;
        logic done;
        logic aborted;
        int cycles;
        int arBefore;
        int awBefore;
        int errorsBefore;
        int testsRun;
        int testsFailed;
        wordT data;
        addrT lineAddr;
        addrT wordAddr;

        aborted = 1'b0;
        testsRun = 0;
        testsFailed = 0;
        reset = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqWdata = '0;
        reqMask = '0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        compareValue("idleOutputs", 64'({respDone, arValid, awValid, wValid, rReady}), 64'd0);

        for (int i = 0; i < stepCount && !aborted; i++) begin
            step = steps[i];
            lineAddr = {step.addr[31:4], 4'h0};
            wordAddr = {step.addr[31:3], 3'b000};
            errorsBefore = errorCount + badEvictCount;
            arBefore = arCount;
            awBefore = awCount;
            @(posedge clock);
            #2;
            reqValid = 1'b1;
            reqWrite = step.write;
            reqAddr = step.addr;
            reqWdata = step.data;
            reqMask = step.mask;
            if (step.write) begin
                writtenLines.push_back(lineAddr);
            end
            waitDone(done, cycles, data);
            // done seen, requester lets go after this edge
            @(posedge clock);
            #2;
            reqValid = 1'b0;
            if (!done) begin
                $display("test %0d: no respDone within %0d cycles", i, doneTimeout);
                errorCount++;
                aborted = 1'b1;
            end else begin
                if (step.write) begin
                    shadow[wordAddr] = mergeBytes(expectedWord(wordAddr), step.data, step.mask);
                end else begin
                    compareValue("respData", data, expectedWord(wordAddr));
                end
                // hit answers one cycle after the sampling edge
                if (step.arExpect == arNone) begin
                    compareValue("arTransfers", 64'(arCount - arBefore), 64'd0);
                    compareValue("awTransfers", 64'(awCount - awBefore), 64'd0);
                    compareValue("hitLatency", 64'(cycles - 1), 64'd1);
                end else if (step.arExpect == arOne) begin
                    compareValue("arTransfers", 64'(arCount - arBefore), 64'd1);
                    compareValue("arAddr", 64'(lastArAddr), 64'(lineAddr));
                end
                if (step.evictExpect && awCount == 0) begin
                    $display("test %0d: set overfilled but no line was written back", i);
                    errorCount++;
                end
            end
            testsRun++;
            if (errorCount + badEvictCount != errorsBefore) begin
                testsFailed++;
            end
            $display("test %0d %s %h: %s", i, step.write ? "write" : "read", step.addr,
                     (errorCount + badEvictCount == errorsBefore) ? "ok" : "failed");
        end

        errorCount = errorCount + badEvictCount + stallCount
                     + dut_i.burstPort_i.assertions_i.failCount;
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/cachePkg.sv
design/entryArray.sv
design/tagDirectory.sv
design/lineStore.sv
design/missController.sv
design/burstPort.sv
design/cacheTop.sv
verif/cache_assertions.sv
verif/memoryModel.sv
verif/cacheTb.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench, result taken from sim.log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module cacheTb -f sources.f -o cacheSim &&
./obj_dir/cacheSim | tee sim.log &&
grep -q "^NO ERRORS$" sim.log &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
